// ==== Makefile ====
TOP := tb_riscv_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF "Done: no errors"

clean:
	rm -rf obj_dir

// ==== logic/alu.sv ====
`timescale 1ns/10ps

module alu
    import riscv_pkg::*;
(
    input  alu_op_e     op,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] result,
    output logic        equal
);

    logic [4:0] shamt;

    assign shamt = b[4:0];  // rv32i uses the low five bits only

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_SLT: begin
                result = {31'b0, $signed(a) < $signed(b)};
            end
            ALU_SLL: begin
                result = a << shamt;
            end
            ALU_SRL: begin
                result = a >> shamt;  // logical
            end
            ALU_PASS_B: begin
                result = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // branch compare, beq and bne
    assign equal = (a == b);

endmodule

// ==== logic/decode_unit.sv ====
`timescale 1ns/10ps
`include "riscv_defines.svh"

module decode_unit
    import riscv_pkg::*;
(
    input  logic [31:0] instr,
    output decode_t     dec
);

    logic [2:0]          funct3;
    logic                alt;      // funct7 bit 5, sub vs add
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_j;

    assign funct3 = instr[14:12];
    assign alt    = instr[30];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        dec           = '0;
        dec.alu_op    = ALU_ADD;
        dec.rd        = instr[`RV_RD_LSB +: 5];
        dec.rs1       = instr[`RV_RS1_LSB +: 5];
        dec.rs2       = instr[`RV_RS2_LSB +: 5];
        dec.imm       = imm_i;

        case (opcode_e'(instr[`RV_OPC_LSB +: 7]))
            OPC_OP: begin
                dec.reg_write = 1'b1;
                case (funct3)
                    3'b000:  dec.alu_op = alt ? ALU_SUB : ALU_ADD;
                    3'b111:  dec.alu_op = ALU_AND;
                    3'b110:  dec.alu_op = ALU_OR;
                    3'b100:  dec.alu_op = ALU_XOR;
                    3'b010:  dec.alu_op = ALU_SLT;
                    3'b001:  dec.alu_op = ALU_SLL;
                    3'b101:  dec.alu_op = ALU_SRL;
                    default: dec.reg_write = 1'b0;  // sltu not supported
                endcase
            end
            OPC_OP_IMM: begin
                dec.reg_write = 1'b1;
                dec.use_imm   = 1'b1;
                case (funct3)
                    3'b000:  dec.alu_op = ALU_ADD;
                    3'b111:  dec.alu_op = ALU_AND;
                    3'b110:  dec.alu_op = ALU_OR;
                    3'b100:  dec.alu_op = ALU_XOR;
                    default: dec.reg_write = 1'b0;
                endcase
            end
            OPC_LUI: begin
                dec.reg_write = 1'b1;
                dec.use_imm   = 1'b1;
                dec.alu_op    = ALU_PASS_B;
                dec.imm       = imm_u;
            end
            OPC_BRANCH: begin
                dec.imm       = imm_b;
                dec.alu_op    = ALU_SUB;
                // only beq and bne
                dec.is_branch = (funct3 == 3'b000) || (funct3 == 3'b001);
                dec.branch_ne = funct3[0];
            end
            OPC_JAL: begin
                dec.reg_write = 1'b1;
                dec.is_jal    = 1'b1;
                dec.imm       = imm_j;
            end
            default: begin
                dec.reg_write = 1'b0;  // unknown, behaves as nop
            end
        endcase
    end

endmodule

// ==== logic/execute_stage.sv ====
`timescale 1ns/10ps
`include "riscv_defines.svh"

module execute_stage
    import riscv_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  fetch_t    fetch,
    output redirect_t redirect,
    output retire_t   retire
);

    decode_t             dec;
    logic [`RV_XLEN-1:0] regs [32];
    logic [`RV_XLEN-1:0] rs1_val;
    logic [`RV_XLEN-1:0] rs2_val;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_result;
    logic                alu_equal;
    logic [`RV_XLEN-1:0] wb_data;
    logic                wb_en;
    logic                taken;

    decode_unit u_decode (
        .instr (fetch.instr),
        .dec   (dec)
    );

    // write port fed from the retire register
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (retire.valid) begin
            regs[retire.rd] <= retire.data;  // rd never zero here
        end
    end

    // x0 reads zero, forward from writeback on an rd match
    assign rs1_val = (dec.rs1 == 5'd0) ? '0 :
                     (retire.valid && retire.rd == dec.rs1) ? retire.data : regs[dec.rs1];
    assign rs2_val = (dec.rs2 == 5'd0) ? '0 :
                     (retire.valid && retire.rd == dec.rs2) ? retire.data : regs[dec.rs2];

    assign alu_b = dec.use_imm ? dec.imm : rs2_val;

    alu u_alu (
        .op     (dec.alu_op),
        .a      (rs1_val),
        .b      (alu_b),
        .result (alu_result),
        .equal  (alu_equal)
    );

    assign wb_data = dec.is_jal ? fetch.pc + `RV_XLEN'd4 : alu_result;  // link address
    assign wb_en   = fetch.valid && dec.reg_write && (dec.rd != 5'd0);

    assign taken          = dec.is_branch && (alu_equal ^ dec.branch_ne);
    assign redirect.valid = fetch.valid && (taken || dec.is_jal);
    assign redirect.pc    = fetch.pc + dec.imm;  // both b and j are pc relative

    always_ff @(posedge clk) begin
        if (rst) begin
            retire.valid <= 1'b0;
        end else begin
            retire.valid <= wb_en;
        end
        retire.pc   <= fetch.pc;
        retire.rd   <= dec.rd;
        retire.data <= wb_data;
    end

    // the slot behind a taken transfer is squashed and must not steer the pc
    squashed_no_redirect: assert property (
        @(posedge clk) disable iff (rst)
        redirect.valid |=> !redirect.valid
    ) else $error("redirect raised on the squashed slot");

endmodule

// ==== logic/fetch_unit.sv ====
`timescale 1ns/10ps
`include "riscv_defines.svh"

module fetch_unit
    import riscv_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  imem_write_t load,
    input  redirect_t   redirect,
    output fetch_t      fetch
);

    logic [31:0]         imem [2**`RV_IMEM_AW];
    logic [`RV_XLEN-1:0] pc;         // address being read this cycle
    logic                issue;      // pc is live, low for one cycle after reset
    logic                fetch_valid;
    logic [`RV_XLEN-1:0] fetch_pc;
    logic [31:0]         fetch_instr;

    // load port writes during reset, read is synchronous
    always_ff @(posedge clk) begin
        if (rst && load.valid) begin
            imem[load.addr] <= load.instr;
        end
        fetch_instr <= imem[pc[`RV_IMEM_AW+1:2]];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= `RV_RESET_PC;
            issue       <= 1'b0;
            fetch_valid <= 1'b0;
        end else if (redirect.valid) begin
            // word read this edge is the fall-through, drop it
            pc          <= redirect.pc;
            issue       <= 1'b1;
            fetch_valid <= 1'b0;
        end else begin
            if (issue) begin
                pc <= pc + `RV_XLEN'd4;
            end
            issue       <= 1'b1;
            fetch_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        fetch_pc <= pc;  // travels with the read data
    end

    assign fetch.valid = fetch_valid;
    assign fetch.pc    = fetch_pc;
    assign fetch.instr = fetch_instr;

    // program is only loaded while the core is held in reset
    load_in_reset: assert property (
        @(posedge clk) load.valid |-> rst
    ) else $error("imem load seen outside reset");

    // one bubble, then the target comes out of memory
    redirect_bubble: assert property (
        @(posedge clk) disable iff (rst)
        redirect.valid |=> !fetch.valid ##1
            (fetch.valid && fetch.pc == $past(redirect.pc, 2))
    ) else $error("redirect did not produce exactly one bubble");

endmodule

// ==== logic/riscv_core.sv ====
`timescale 1ns/10ps

module riscv_core
    import riscv_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  imem_write_t load,
    output retire_t     retire
);

    fetch_t    fetch;     // fetch to execute
    redirect_t redirect;  // execute back to fetch

    // pc, instruction memory and squash
    fetch_unit u_fetch (
        .clk      (clk),
        .rst      (rst),
        .load     (load),
        .redirect (redirect),
        .fetch    (fetch)
    );

    // decode, register file, alu and writeback
    execute_stage u_execute (
        .clk      (clk),
        .rst      (rst),
        .fetch    (fetch),
        .redirect (redirect),
        .retire   (retire)
    );

endmodule

// ==== logic/riscv_defines.svh ====
`ifndef RISCV_DEFINES_SVH
`define RISCV_DEFINES_SVH

// datapath and register width
`define RV_XLEN 32

// instruction memory is word addressed, 256 words
`define RV_IMEM_AW 8

// first fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

// fixed RV32I field positions
`define RV_OPC_LSB 0
`define RV_RD_LSB 7
`define RV_RS1_LSB 15
`define RV_RS2_LSB 20

`endif

// ==== logic/riscv_pkg.sv ====
`include "riscv_defines.svh"

package riscv_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLL    = 4'd6,
        ALU_SRL    = 4'd7,
        ALU_PASS_B = 4'd8  // lui
    } alu_op_e;

    // program load port, only honored in reset
    typedef struct packed {
        logic                   valid;
        logic [`RV_IMEM_AW-1:0] addr;   // word address
        logic [31:0]            instr;
    } imem_write_t;

    typedef struct packed {
        logic               valid;
        logic [`RV_XLEN-1:0] pc;
        logic [31:0]        instr;
    } fetch_t;

    typedef struct packed {
        alu_op_e             alu_op;
        logic                use_imm;    // b operand from imm
        logic                reg_write;
        logic                is_branch;
        logic                branch_ne;  // bne, else beq
        logic                is_jal;
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [`RV_XLEN-1:0] imm;
    } decode_t;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] data;
    } retire_t;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;    // target
    } redirect_t;

endpackage

// ==== sim.f ====
+incdir+logic
+incdir+testbench
logic/riscv_pkg.sv
logic/alu.sv
logic/decode_unit.sv
logic/fetch_unit.sv
logic/execute_stage.sv
logic/riscv_core.sv
testbench/tb_riscv_core.sv

// ==== testbench/riscv_testdata.txt ====
# L word_addr instr : program word written through the load port during reset
# E pc rd data : expected retire in program order, S name starts a test section
S alu_imm
L 00 00500093
L 01 ffd00113
L 02 0ff0c193
L 03 1000e213
L 04 7f017293
L 05 12345337
E 00 01 00000005
E 04 02 fffffffd
E 08 03 000000fa
E 0c 04 00000105
E 10 05 000007f0
E 14 06 12345000
S alu_reg
L 06 002083b3
L 07 40208433
L 08 0051f4b3
L 09 00326533
L 0a 004345b3
L 0b 00112633
L 0c 001096b3
L 0d 00115733
E 18 07 00000002
E 1c 08 00000008
E 20 09 000000f0
E 24 0a 000001ff
E 28 0b 12345105
E 2c 0c 00000001
E 30 0d 000000a0
E 34 0e 07ffffff
S forward
L 0e 00100793
L 0f 00f787b3
L 10 00f787b3
L 11 40178833
L 12 00f828b3
E 38 0f 00000001
E 3c 0f 00000002
E 40 0f 00000004
E 44 10 ffffffff
E 48 11 00000001
S x0_writes
L 13 07b00013
L 14 00100933
L 15 00108033
L 16 000069b3
E 50 12 00000005
E 58 13 00000000
S branch
L 17 01208463
L 18 06300a13
L 19 01209463
L 1a 00700a13
L 1b 001a1463
L 1c 06300a93
L 1d 001a0463
L 1e 00b00a93
E 68 14 00000007
E 78 15 0000000b
S jal
L 1f 00c00b6f
L 20 06300b93
L 21 06200b93
L 22 015b0c33
L 23 0000006f
E 7c 16 00000080
E 88 18 0000008b

// ==== testbench/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int error_count = 0;
int check_count = 0;

task automatic check_pc(
    input logic [`RV_XLEN-1:0] exp_pc,
    input logic [`RV_XLEN-1:0] got_pc
);
    check_count++;
    if (got_pc !== exp_pc) begin
        error_count++;
        $display("error at %0t: retire.pc expected %h got %h", $time, exp_pc, got_pc);
    end
endtask

task automatic check_rd(
    input logic [4:0] exp_rd,
    input logic [4:0] got_rd
);
    check_count++;
    if (got_rd !== exp_rd) begin
        error_count++;
        $display("error at %0t: retire.rd expected x%0d got x%0d", $time, exp_rd, got_rd);
    end
endtask

task automatic check_data(
    input logic [`RV_XLEN-1:0] exp_data,
    input logic [`RV_XLEN-1:0] got_data
);
    check_count++;
    if (got_data !== exp_data) begin
        error_count++;
        $display("error at %0t: retire.data expected %h got %h", $time, exp_data, got_data);
    end
endtask

`endif

// ==== testbench/tb_riscv_core.sv ====
`timescale 1ns/10ps
`include "riscv_defines.svh"

module tb_riscv_core
    import riscv_pkg::*;
();

    localparam int CLK_NS       = 4;
    localparam int QUIET_CYCLES = 16;  // self-loop runs, nothing may retire

    logic        clk;
    logic        rst;
    imem_write_t load;
    retire_t     retire;

    imem_write_t load_q[$];
    retire_t     exp_q[$];
    string       end_q[$];          // section name on the last retire of a section
    bit          parsed = 1'b0;
    int          sect_err_start = 0;
    int          sect_retires = 0;

    `include "tb_checks.svh"

    riscv_core u_dut (
        .clk    (clk),
        .rst    (rst),
        .load   (load),
        .retire (retire)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    function automatic void mark_section_end(input string name);
        if (name != "" && end_q.size() > 0) begin
            end_q[end_q.size() - 1] = name;
        end
    endfunction

    task automatic read_testdata();
        int          fd;
        int          code;
        string       tag;
        string       cur_sect;
        string       line;
        logic [31:0] f_a;
        logic [31:0] f_b;
        logic [31:0] f_c;
        imem_write_t w;
        retire_t     e;

        cur_sect = "";
        fd = $fopen("testbench/riscv_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open testbench/riscv_testdata.txt");
            error_count++;
            return;
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                code = $fgets(line, fd);  // rest of a comment line
            end else if (tag == "S") begin
                mark_section_end(cur_sect);
                code = $fscanf(fd, "%s", cur_sect);
                if (code != 1) begin
                    $display("section record without a name in the test data");
                    error_count++;
                end
            end else if (tag == "L") begin
                code = $fscanf(fd, "%h %h", f_a, f_b);
                if (code != 2) begin
                    $display("malformed load record in the test data");
                    error_count++;
                end
                w.valid = 1'b1;
                w.addr  = f_a[`RV_IMEM_AW-1:0];
                w.instr = f_b;
                load_q.push_back(w);
            end else if (tag == "E") begin
                code = $fscanf(fd, "%h %h %h", f_a, f_b, f_c);
                if (code != 3) begin
                    $display("malformed expected retire record in the test data");
                    error_count++;
                end
                e.valid = 1'b1;
                e.pc    = f_a;
                e.rd    = f_b[4:0];
                e.data  = f_c;
                exp_q.push_back(e);
                end_q.push_back("");
            end else begin
                $display("unknown record '%s' in the test data", tag);
                error_count++;
            end
        end
        mark_section_end(cur_sect);
        $fclose(fd);
    endtask

    task automatic match_retire();
        retire_t exp_r;
        string   sect;

        exp_r = exp_q.pop_front();
        sect  = end_q.pop_front();
        check_pc(exp_r.pc, retire.pc);
        check_rd(exp_r.rd, retire.rd);
        check_data(exp_r.data, retire.data);
        sect_retires++;
        if (sect != "") begin
            if (error_count == sect_err_start) begin
                $display("test %s: passed, %0d retires", sect, sect_retires);
            end else begin
                $display("test %s: failed, %0d errors in %0d retires",
                         sect, error_count - sect_err_start, sect_retires);
            end
            sect_err_start = error_count;
            sect_retires   = 0;
        end
    endtask

    // retire is registered, so look at it on the falling edge
    always @(negedge clk) begin
        if (!rst && retire.valid) begin
            if (exp_q.size() == 0) begin
                error_count++;
                $display("retire of x%0d at pc %h after the last expected retire",
                         retire.rd, retire.pc);
            end else begin
                match_retire();
            end
        end
    end

    initial begin
        $timeformat(-9, 1, " ns", 0);
        rst  = 1'b1;
        load = '0;
        read_testdata();
        parsed = 1'b1;
        repeat (5) @(posedge clk);
        foreach (load_q[i]) begin
            @(posedge clk);
            #1;
            load = load_q[i];
        end
        @(posedge clk);
        #1;
        load = '0;
        rst  = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (QUIET_CYCLES) @(posedge clk);
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // watchdog, scaled by the program length
    initial begin
        int limit_ns;

        wait (parsed);
        limit_ns = CLK_NS * (20 + 4 * load_q.size());
        #(limit_ns);
        $display("timeout: %0d expected retires still pending after %0d ns",
                 exp_q.size(), limit_ns);
        $display("Done: errors found");
        $finish;
    end

endmodule
